/* verilog/besm_uinstr_pkg.sv */
package besm_uinstr_pkg;

    typedef logic [23:0] uword_t;           // Reduced microinstruction

    typedef logic [3:0]  ydst_t;            // Y bus destination
    typedef logic [3:0]  arbop_t;           // Arbiter operation
    typedef logic [4:0]  ffcnt_t;           // Flag-trigger action
    typedef logic [4:0]  cond_sel_t;        // Condition select

    // ----------------------------------------
    // Field positions, LSB of each field
    localparam int UW_ICC_BIT   = 0;        // Condition polarity, 1 = direct
    localparam int UW_COND_LSB  = 1;        // COND [5:1]
    localparam int UW_FFCNT_LSB = 6;        // FFCNT [10:6]
    localparam int UW_IOMP_BIT  = 11;       // 0 = flag decoder selected
    localparam int UW_DDEV_LSB  = 12;       // DDEV [14:12]
    localparam int UW_DDEV_W    = 3;
    localparam int UW_ISE_BIT   = 15;       // Copy TKK into RCB
    localparam int UW_ARBI_LSB  = 16;       // ARBI [19:16]
    localparam int UW_YDST_LSB  = 20;       // YDST [23:20]

    // ----------------------------------------
    // Y destinations and D device codes
    localparam ydst_t YDST_RR     = 4'd3;   // Mode register
    localparam ydst_t YDST_ARB    = 4'd5;   // Arbiter opcode from Y
    localparam ydst_t YDST_ADRREG = 4'd8;   // Effective address register
    localparam logic [UW_DDEV_W-1:0] DDEV_CLRCB = 3'd3;  // Extra CB clear

    // ----------------------------------------
    // Flag-trigger codes
    localparam ffcnt_t LOGGRP = 5'd1;       // Logic group
    localparam ffcnt_t MULGRP = 5'd2;       // Multiply group
    localparam ffcnt_t ADDGRP = 5'd3;       // Add group
    localparam ffcnt_t SETC   = 5'd5;       // Set CB
    localparam ffcnt_t CLRRCB = 5'd6;
    localparam ffcnt_t SETRCB = 5'd7;
    localparam ffcnt_t CLRJMP = 5'd8;
    localparam ffcnt_t SETJMP = 5'd9;
    localparam ffcnt_t SETEI  = 5'd10;      // Unmask interrupts
    localparam ffcnt_t CLREI  = 5'd11;      // Mask interrupts
    localparam ffcnt_t CLRTR0 = 5'd12;
    localparam ffcnt_t SETTR0 = 5'd13;
    localparam ffcnt_t CLRTR1 = 5'd14;
    localparam ffcnt_t SETTR1 = 5'd15;
    localparam ffcnt_t CLRTKK = 5'd18;
    localparam ffcnt_t SETTKK = 5'd19;
    localparam ffcnt_t SETNR  = 5'd20;      // Native mode
    localparam ffcnt_t SETER  = 5'd22;      // Emulation mode
    localparam ffcnt_t CHTKK  = 5'd23;      // Toggle TKK

    // ----------------------------------------
    // Condition codes
    localparam cond_sel_t COND_YES    = 5'd0;
    localparam cond_sel_t COND_NORMB  = 5'd1;
    localparam cond_sel_t COND_RNDB   = 5'd2;
    localparam cond_sel_t COND_OVRIB  = 5'd3;
    localparam cond_sel_t COND_BNB    = 5'd4;
    localparam cond_sel_t COND_OVRFTB = 5'd5;
    localparam cond_sel_t COND_DRG    = 5'd6;
    localparam cond_sel_t COND_EMLRG  = 5'd7;
    localparam cond_sel_t COND_RCB    = 5'd8;
    localparam cond_sel_t COND_CB     = 5'd9;
    localparam cond_sel_t COND_CEMLRG = 5'd10;
    localparam cond_sel_t COND_CT     = 5'd11;  // Status unit, not in this slice
    localparam cond_sel_t COND_TR1    = 5'd12;
    localparam cond_sel_t COND_INTSTP = 5'd13;
    localparam cond_sel_t COND_IR15   = 5'd14;  // Decoder, not in this slice
    localparam cond_sel_t COND_TKK    = 5'd15;
    localparam cond_sel_t COND_ARBRDY = 5'd21;
    localparam cond_sel_t COND_TR0    = 5'd22;

endpackage

/* verilog/besm_state_pkg.sv */
package besm_state_pkg;

    typedef logic [31:0] word_t;            // Low half of the Y bus
    typedef logic [31:0] rr_t;              // Mode register
    typedef logic [2:0]  grp_t;             // One-hot instruction group
    typedef logic [2:0]  credit_t;          // Request credit count

    // ----------------------------------------
    // Mode register bit positions
    localparam int RR_NORMB       = 0;      // Normalization block
    localparam int RR_RNDB        = 1;      // Rounding block
    localparam int RR_GRP_LSB     = 2;      // Group field, bits 4..2
    localparam int RR_OVRIB       = 5;      // Overflow interrupt block
    localparam int RR_V           = 6;
    localparam int RR_C           = 7;
    localparam int RR_N           = 8;
    localparam int RR_Z           = 9;
    localparam int RR_BNB         = 10;     // BESM-6 range check block
    localparam int RR_OVRFTB      = 11;
    localparam int RR_DRG         = 12;     // Dispatcher mode
    localparam int RR_NO_BADOP    = 13;
    localparam int RR_NO_RTAG     = 14;
    localparam int RR_NO_BADACC   = 15;
    localparam int RR_NO_PROGTAG  = 16;
    localparam int RR_NO_INTR     = 17;     // External interrupt mask
    localparam int RR_NO_WTAG     = 18;
    localparam int RR_CEMLRG      = 19;     // Reserve bit, testable
    localparam int RR_SINGLE_STEP = 20;
    localparam int RR_INTSTP      = 21;     // Stop on interrupt
    localparam int RR_NO_WPROT    = 22;
    localparam int RR_NO_RPROT    = 23;
    localparam int RR_NEGADDR     = 24;
    localparam int RR_NO_PROCNM   = 25;
    localparam int RR_NO_PAGING   = 26;
    localparam int RR_CB          = 27;     // Address changed by reg 16
    localparam int RR_RCB         = 28;     // Right-command flag
    localparam int RR_JUMP        = 29;     // Control transfer flag
    // Bits 30 and 31 are spare and simply follow Y

    // ----------------------------------------
    // Group encodings
    localparam grp_t GRP_LOG = 3'b001;
    localparam grp_t GRP_MUL = 3'b010;
    localparam grp_t GRP_ADD = 3'b100;

    localparam credit_t ARB_CREDITS = 3'd4; // Requests memory side can take

endpackage

/* verilog/besm_mode_reg.sv */
`timescale 1ns/1ns

module besm_mode_reg
    import besm_uinstr_pkg::*, besm_state_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   i_uvalid,                // Microinstruction present
    input  uword_t i_uword,
    input  word_t  i_y,                     // Y bus, low half
    output rr_t    o_rr,                    // Current mode register
    output logic   o_tr0,                   // Microprogram flag 0
    output logic   o_tr1,                   // Microprogram flag 1
    output logic   o_tkk,                   // Standardizer right-command flag
    output logic   o_emul                   // Emulation mode
);

    ydst_t                ydst;
    ffcnt_t               ffcnt;
    logic [UW_DDEV_W-1:0] ddev;
    logic                 iomp;
    logic                 ise;
    logic                 ff_en;            // Flag decoder active
    logic                 ld_rr;            // Y load of the whole register

    rr_t  rr_q;
    rr_t  rr_d;
    logic tr0_q, tr0_d;
    logic tr1_q, tr1_d;
    logic tkk_q, tkk_d;
    logic emul_q, emul_d;

    // ----------------------------------------
    // Field decode
    assign ydst  = i_uword[UW_YDST_LSB +: $bits(ydst_t)];
    assign ffcnt = i_uword[UW_FFCNT_LSB +: $bits(ffcnt_t)];
    assign ddev  = i_uword[UW_DDEV_LSB +: UW_DDEV_W];
    assign iomp  = i_uword[UW_IOMP_BIT];
    assign ise   = i_uword[UW_ISE_BIT];

    assign ff_en = i_uvalid && !iomp;       // IOMP=1 selects clock/timer
    assign ld_rr = i_uvalid && (ydst == YDST_RR);

    // ----------------------------------------
    // Next state
    always_comb begin
        rr_d   = ld_rr ? i_y : rr_q;        // Y load first, actions override
        tr0_d  = tr0_q;
        tr1_d  = tr1_q;
        tkk_d  = tkk_q;
        emul_d = emul_q;

        if (ff_en) begin
            case (ffcnt)
                LOGGRP:  rr_d[RR_GRP_LSB +: $bits(grp_t)] = GRP_LOG;
                MULGRP:  rr_d[RR_GRP_LSB +: $bits(grp_t)] = GRP_MUL;
                ADDGRP:  rr_d[RR_GRP_LSB +: $bits(grp_t)] = GRP_ADD;
                CLRJMP:  rr_d[RR_JUMP] = 1'b0;
                SETJMP:  rr_d[RR_JUMP] = 1'b1;
                SETEI:   rr_d[RR_NO_INTR] = 1'b0;   // Interrupts enabled
                CLREI:   rr_d[RR_NO_INTR] = 1'b1;   // Interrupts masked
                CLRTR0:  tr0_d = 1'b0;
                SETTR0:  tr0_d = 1'b1;
                CLRTR1:  tr1_d = 1'b0;
                SETTR1:  tr1_d = 1'b1;
                CLRTKK:  tkk_d = 1'b0;
                SETTKK:  tkk_d = 1'b1;
                SETNR:   emul_d = 1'b0;
                SETER:   emul_d = 1'b1;
                CHTKK:   tkk_d = ~tkk_q;            // Counting mode
                default: ;                          // CB and RCB handled below
            endcase
        end

        // CB has its own path from DDEV
        if (i_uvalid && (ddev == DDEV_CLRCB)) begin
            rr_d[RR_CB] = 1'b0;                     // Clear wins
        end else if (ff_en && (ffcnt == SETC)) begin
            rr_d[RR_CB] = 1'b1;
        end

        // RCB takes the old TKK on ISE
        if (i_uvalid && ise) begin
            rr_d[RR_RCB] = tkk_q;
        end else if (ff_en && (ffcnt == CLRRCB)) begin
            rr_d[RR_RCB] = 1'b0;
        end else if (ff_en && (ffcnt == SETRCB)) begin
            rr_d[RR_RCB] = 1'b1;
        end
    end

    // ----------------------------------------
    // Registers
    always_ff @(posedge clk) begin
        if (reset) begin
            rr_q   <= '0;
            tr0_q  <= 1'b0;
            tr1_q  <= 1'b0;
            tkk_q  <= 1'b0;
            emul_q <= 1'b0;                 // Native mode after reset
        end else begin
            rr_q   <= rr_d;
            tr0_q  <= tr0_d;
            tr1_q  <= tr1_d;
            tkk_q  <= tkk_d;
            emul_q <= emul_d;
        end
    end

    assign o_rr   = rr_q;
    assign o_tr0  = tr0_q;
    assign o_tr1  = tr1_q;
    assign o_tkk  = tkk_q;
    assign o_emul = emul_q;

endmodule

/* verilog/besm_cond_mux.sv */
`timescale 1ns/1ns

module besm_cond_mux
    import besm_uinstr_pkg::*, besm_state_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   i_uvalid,
    input  uword_t i_uword,
    input  rr_t    i_rr,                    // Mode register before the edge
    input  logic   i_tr0,
    input  logic   i_tr1,
    input  logic   i_tkk,
    input  logic   i_emul,
    input  logic   i_arb_rdy,               // Request issues this cycle
    output logic   o_cond_valid,
    output logic   o_cond
);

    cond_sel_t cond_sel;
    logic      icc;
    logic      cond_raw;                    // Selected source
    logic      cond_pol;                    // After polarity

    assign cond_sel = i_uword[UW_COND_LSB +: $bits(cond_sel_t)];
    assign icc      = i_uword[UW_ICC_BIT];

    // ----------------------------------------
    // Source select
    always_comb begin
        case (cond_sel)
            COND_YES:    cond_raw = 1'b1;
            COND_NORMB:  cond_raw = i_rr[RR_NORMB];
            COND_RNDB:   cond_raw = i_rr[RR_RNDB];
            COND_OVRIB:  cond_raw = i_rr[RR_OVRIB];
            COND_BNB:    cond_raw = i_rr[RR_BNB];
            COND_OVRFTB: cond_raw = i_rr[RR_OVRFTB];
            COND_DRG:    cond_raw = i_rr[RR_DRG];
            COND_EMLRG:  cond_raw = i_emul;
            COND_RCB:    cond_raw = i_rr[RR_RCB];
            COND_CB:     cond_raw = i_rr[RR_CB];
            COND_CEMLRG: cond_raw = i_rr[RR_CEMLRG];
            COND_CT:     cond_raw = 1'b1;       // No status unit here
            COND_TR1:    cond_raw = i_tr1;
            COND_INTSTP: cond_raw = i_rr[RR_INTSTP];
            COND_IR15:   cond_raw = 1'b1;       // No decoder here
            COND_TKK:    cond_raw = i_tkk;
            COND_ARBRDY: cond_raw = i_arb_rdy;
            COND_TR0:    cond_raw = i_tr0;
            default:     cond_raw = 1'b1;       // RUN, INT, FULMEM, CPMP and spare
        endcase
    end

    assign cond_pol = icc ? cond_raw : ~cond_raw;   // ICC=0 inverts

    // ----------------------------------------
    // Output stage, one cycle latency
    always_ff @(posedge clk) begin
        if (reset) begin
            o_cond_valid <= 1'b0;
            o_cond       <= 1'b0;
        end else begin
            o_cond_valid <= i_uvalid;
            o_cond       <= cond_pol;       // Qualified by o_cond_valid
        end
    end

endmodule

/* verilog/besm_arb_req.sv */
`timescale 1ns/1ns

module besm_arb_req
    import besm_uinstr_pkg::*, besm_state_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   i_uvalid,
    input  uword_t i_uword,
    input  word_t  i_y,
    input  logic   i_credit,                // One credit back per pulse
    output logic   o_arb_rdy,               // Issue this cycle
    output logic   o_req_valid,
    output arbop_t o_req_op,
    output word_t  o_req_addr
);

    ydst_t   ydst;
    arbop_t  arbi;
    arbop_t  req_q;                         // Pending arbiter opcode
    word_t   addr_q;                        // Effective address register
    credit_t credits_q;
    logic    issue;

    assign ydst = i_uword[UW_YDST_LSB +: $bits(ydst_t)];
    assign arbi = i_uword[UW_ARBI_LSB +: $bits(arbop_t)];

    // Issue needs a pending op and a free slot downstream
    assign issue       = (req_q != '0) && (credits_q != '0);
    assign o_req_valid = issue;
    assign o_arb_rdy   = issue;
    assign o_req_op    = req_q;
    assign o_req_addr  = addr_q;

    // ----------------------------------------
    // Request register
    always_ff @(posedge clk) begin
        if (reset) begin
            req_q <= '0;
        end else if (issue) begin
            req_q <= '0;                    // Clear on issue, loads lost
        end else if (i_uvalid && (ydst == YDST_ARB)) begin
            req_q <= i_y[$bits(arbop_t)-1:0];   // Opcode from Y
        end else if (i_uvalid && (arbi != '0)) begin
            req_q <= arbi;                  // Opcode from microinstruction
        end
    end

    // ----------------------------------------
    // Address register
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_q <= '0;
        end else if (i_uvalid && (ydst == YDST_ADRREG)) begin
            addr_q <= i_y;
        end
    end

    // ----------------------------------------
    // Credit counter
    always_ff @(posedge clk) begin
        if (reset) begin
            credits_q <= ARB_CREDITS;       // Memory side starts empty
        end else begin
            case ({issue, i_credit})
                2'b10: credits_q <= credits_q - credit_t'(1);
                2'b01: begin
                    if (credits_q < ARB_CREDITS) begin
                        credits_q <= credits_q + credit_t'(1);  // Saturate
                    end
                end
                default: ;                  // Both or neither, no change
            endcase
        end
    end

    credit_max_a: assert property (@(posedge clk) disable iff (reset)
        credits_q <= ARB_CREDITS)
        else $error("Credit count above limit");

    // Spending the last credit stalls the next cycle
    last_credit_a: assert property (@(posedge clk) disable iff (reset)
        issue && (credits_q == credit_t'(1)) && !i_credit |=> !o_req_valid)
        else $error("Request issued with no credit left");

endmodule

/* verilog/besm_ctl_top.sv */
`timescale 1ns/1ns

module besm_ctl_top
    import besm_uinstr_pkg::*, besm_state_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   i_uvalid,
    input  uword_t i_uword,
    input  word_t  i_y,
    input  logic   i_credit,
    output rr_t    o_rr,
    output logic   o_cond_valid,
    output logic   o_cond,
    output logic   o_req_valid,
    output arbop_t o_req_op,
    output word_t  o_req_addr
);

    logic tr0;                              // Flags into condition mux
    logic tr1;
    logic tkk;
    logic emul;
    logic arb_rdy;                          // Issue strobe from arbiter

    besm_mode_reg mode_reg_i (
        .clk      (clk),
        .reset    (reset),
        .i_uvalid (i_uvalid),
        .i_uword  (i_uword),
        .i_y      (i_y),
        .o_rr     (o_rr),
        .o_tr0    (tr0),
        .o_tr1    (tr1),
        .o_tkk    (tkk),
        .o_emul   (emul)
    );

    besm_cond_mux cond_mux_i (
        .clk          (clk),
        .reset        (reset),
        .i_uvalid     (i_uvalid),
        .i_uword      (i_uword),
        .i_rr         (o_rr),
        .i_tr0        (tr0),
        .i_tr1        (tr1),
        .i_tkk        (tkk),
        .i_emul       (emul),
        .i_arb_rdy    (arb_rdy),
        .o_cond_valid (o_cond_valid),
        .o_cond       (o_cond)
    );

    besm_arb_req arb_req_i (
        .clk         (clk),
        .reset       (reset),
        .i_uvalid    (i_uvalid),
        .i_uword     (i_uword),
        .i_y         (i_y),
        .i_credit    (i_credit),
        .o_arb_rdy   (arb_rdy),
        .o_req_valid (o_req_valid),
        .o_req_op    (o_req_op),
        .o_req_addr  (o_req_addr)
    );

endmodule

/* include/tb_besm_model.svh */
`ifndef TB_BESM_MODEL_SVH
`define TB_BESM_MODEL_SVH

// ----------------------------------------
// Reference state as it stands after the last edge
rr_t    m_rr;
logic   m_tr0;
logic   m_tr1;
logic   m_tkk;
logic   m_emul;
arbop_t m_req;                              // Pending arbiter op
word_t  m_addr;
int     m_credits;
int     m_outstanding;                      // Issued, credit not back yet
logic   m_cond_valid;
logic   m_cond;

task automatic model_reset();
    m_rr          = '0;
    m_tr0         = 1'b0;
    m_tr1         = 1'b0;
    m_tkk         = 1'b0;
    m_emul        = 1'b0;
    m_req         = '0;
    m_addr        = '0;
    m_credits     = ARB_CREDITS;            // Memory side empty
    m_outstanding = 0;
    m_cond_valid  = 1'b0;
    m_cond        = 1'b0;
endtask

function automatic logic model_issue();
    return (m_req != '0) && (m_credits > 0);
endfunction

function automatic logic cond_source(input cond_sel_t sel, input logic arb_rdy);
    case (sel)
        COND_NORMB:  return m_rr[RR_NORMB];
        COND_RNDB:   return m_rr[RR_RNDB];
        COND_OVRIB:  return m_rr[RR_OVRIB];
        COND_BNB:    return m_rr[RR_BNB];
        COND_OVRFTB: return m_rr[RR_OVRFTB];
        COND_DRG:    return m_rr[RR_DRG];
        COND_EMLRG:  return m_emul;
        COND_RCB:    return m_rr[RR_RCB];
        COND_CB:     return m_rr[RR_CB];
        COND_CEMLRG: return m_rr[RR_CEMLRG];
        COND_TR1:    return m_tr1;
        COND_INTSTP: return m_rr[RR_INTSTP];
        COND_TKK:    return m_tkk;
        COND_ARBRDY: return arb_rdy;
        COND_TR0:    return m_tr0;
        default:     return 1'b1;           // YES and all dropped sources
    endcase
endfunction

// ----------------------------------------
// One rising edge with the inputs of the cycle before it
task automatic model_step(input logic uvalid, input uword_t uw, input word_t y,
                          input logic credit);
    ydst_t  ydst;
    ffcnt_t ff;
    arbop_t arbi;
    logic   ff_on;
    logic   issue;
    logic   src;
    rr_t    nrr;

    ydst  = uw[UW_YDST_LSB +: $bits(ydst_t)];
    ff    = uw[UW_FFCNT_LSB +: $bits(ffcnt_t)];
    arbi  = uw[UW_ARBI_LSB +: $bits(arbop_t)];
    ff_on = uvalid && !uw[UW_IOMP_BIT];
    issue = model_issue();

    src          = cond_source(uw[UW_COND_LSB +: $bits(cond_sel_t)], issue);  // Old state
    m_cond       = uw[UW_ICC_BIT] ? src : !src;
    m_cond_valid = uvalid;

    nrr = (uvalid && (ydst == YDST_RR)) ? y : m_rr;
    if (uvalid && (uw[UW_DDEV_LSB +: UW_DDEV_W] == DDEV_CLRCB)) nrr[RR_CB] = 1'b0;
    else if (ff_on && (ff == SETC)) nrr[RR_CB] = 1'b1;
    if (uvalid && uw[UW_ISE_BIT]) nrr[RR_RCB] = m_tkk;     // TKK before this edge
    else if (ff_on && (ff == CLRRCB)) nrr[RR_RCB] = 1'b0;
    else if (ff_on && (ff == SETRCB)) nrr[RR_RCB] = 1'b1;
    if (ff_on) begin
        case (ff)
            LOGGRP: nrr[RR_GRP_LSB +: 3] = 3'b001;
            MULGRP: nrr[RR_GRP_LSB +: 3] = 3'b010;
            ADDGRP: nrr[RR_GRP_LSB +: 3] = 3'b100;
            CLRJMP: nrr[RR_JUMP] = 1'b0;
            SETJMP: nrr[RR_JUMP] = 1'b1;
            SETEI:  nrr[RR_NO_INTR] = 1'b0;
            CLREI:  nrr[RR_NO_INTR] = 1'b1;
            CLRTR0: m_tr0 = 1'b0;
            SETTR0: m_tr0 = 1'b1;
            CLRTR1: m_tr1 = 1'b0;
            SETTR1: m_tr1 = 1'b1;
            CLRTKK: m_tkk = 1'b0;
            SETTKK: m_tkk = 1'b1;
            SETNR:  m_emul = 1'b0;
            SETER:  m_emul = 1'b1;
            CHTKK:  m_tkk = !m_tkk;
            default: ;
        endcase
    end
    m_rr = nrr;

    // Request path, issue beats both loads
    if (issue) begin
        m_req = '0;
        m_credits--;
        m_outstanding++;
    end else if (uvalid && (ydst == YDST_ARB)) m_req = y[3:0];
    else if (uvalid && (arbi != '0)) m_req = arbi;
    if (uvalid && (ydst == YDST_ADRREG)) m_addr = y;
    if (credit) begin
        if (m_credits < ARB_CREDITS) m_credits++;
        if (m_outstanding > 0) m_outstanding--;
    end
endtask

`endif

/* verif/tb_besm_ctl.sv */
`timescale 1ns/1ns

module tb_besm_ctl
    import besm_uinstr_pkg::*, besm_state_pkg::*;
();

    logic   clk;
    logic   reset;
    logic   i_uvalid;
    uword_t i_uword;
    word_t  i_y;
    logic   i_credit;
    rr_t    o_rr;
    logic   o_cond_valid;
    logic   o_cond;
    logic   o_req_valid;
    arbop_t o_req_op;
    word_t  o_req_addr;
    integer seed;
    int     issued;                         // Requests seen on the bus

    `include "tb_besm_model.svh"

    besm_ctl_top besm_ctl_top_i (.*);

    always #2 clk = ~clk;                   // 4 ns period

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_rr(input rr_t got, input rr_t exp);
        if (got !== exp) stop_run($sformatf("ERR o_rr got %h expected %h", got, exp));
    endtask

    task automatic check_cond(input logic got_v, input logic got, input logic exp_v,
                              input logic exp);
        if (got_v !== exp_v)
            stop_run($sformatf("ERR o_cond_valid got %h expected %h", got_v, exp_v));
        else if (exp_v && (got !== exp))
            stop_run($sformatf("ERR o_cond got %h expected %h", got, exp));
    endtask

    task automatic check_req(input logic got_v, input arbop_t got_op, input word_t got_addr,
                             input logic exp_v, input arbop_t exp_op, input word_t exp_addr);
        if (got_v !== exp_v)
            stop_run($sformatf("ERR o_req_valid got %h expected %h", got_v, exp_v));
        else if (exp_v && (got_op !== exp_op))
            stop_run($sformatf("ERR o_req_op got %h expected %h", got_op, exp_op));
        else if (exp_v && (got_addr !== exp_addr))
            stop_run($sformatf("ERR o_req_addr got %h expected %h", got_addr, exp_addr));
    endtask

    // ----------------------------------------
    // Drive after the edge, compare at the falling edge, then step the model
    task automatic run_cycle(input logic uvalid, input uword_t uw, input word_t y,
                             input logic credit);
        @(posedge clk);
        #1;
        i_uvalid = uvalid;
        i_uword  = uw;
        i_y      = y;
        i_credit = credit;
        @(negedge clk);
        check_rr(o_rr, m_rr);
        check_cond(o_cond_valid, o_cond, m_cond_valid, m_cond);
        check_req(o_req_valid, o_req_op, o_req_addr, model_issue(), m_req, m_addr);
        if (o_req_valid) issued++;
        model_step(uvalid, uw, y, credit);
    endtask

    function automatic uword_t make_uword(input ydst_t ydst, input arbop_t arbi);
        uword_t uw;
        uw = '0;
        uw[UW_YDST_LSB +: $bits(ydst_t)]  = ydst;
        uw[UW_ARBI_LSB +: $bits(arbop_t)] = arbi;
        uw[UW_IOMP_BIT] = 1'b1;             // No flag action
        uw[UW_ICC_BIT]  = 1'b1;
        return uw;
    endfunction

    task automatic random_cycle();
        uword_t uw;
        int     pick;
        logic   uvalid;
        word_t  y;
        logic   credit;
        uw   = uword_t'($random(seed));
        pick = $random(seed) & 3;
        if (pick == 0) uw[UW_YDST_LSB +: $bits(ydst_t)] = YDST_RR;     // Favour live targets
        else if (pick == 1) uw[UW_YDST_LSB +: $bits(ydst_t)] = YDST_ARB;
        else if (pick == 2) uw[UW_YDST_LSB +: $bits(ydst_t)] = YDST_ADRREG;
        if ($random(seed) & 1) uw[UW_ARBI_LSB +: $bits(arbop_t)] = '0;
        uvalid = ($random(seed) & 7) != 0;
        y      = $random(seed);
        credit = (m_outstanding > 0) && (($random(seed) & 1) != 0);  // Only owed credits
        run_cycle(uvalid, uw, y, credit);
    endtask

    task automatic drain_credits();
        int cycles;
        cycles = 0;
        while ((m_outstanding > 0) || (m_req != '0)) begin
            if (cycles == 200) stop_run("credits and pending request did not drain");
            else begin
                run_cycle(1'b0, '0, '0, m_outstanding > 0);
                cycles++;
            end
        end
    endtask

    task automatic wait_request();
        int cycles;
        int start;
        cycles = 0;
        start  = issued;
        while (issued == start) begin
            if (cycles == 200) stop_run("no request issued within 200 cycles");
            else begin
                run_cycle(1'b0, '0, '0, 1'b0);
                cycles++;
            end
        end
    endtask

    // ----------------------------------------
    initial begin
        seed     = 13;
        clk      = 1'b0;
        reset    = 1'b1;
        i_uvalid = 1'b0;
        i_uword  = '0;
        i_y      = '0;
        i_credit = 1'b0;
        issued   = 0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_rr(o_rr, '0);                 // Reset state
        check_cond(o_cond_valid, o_cond, 1'b0, 1'b0);
        check_req(o_req_valid, o_req_op, o_req_addr, 1'b0, '0, '0);
        model_reset();
        model_step(1'b0, '0, '0, 1'b0);     // Idle edge right after reset

        repeat (3000) random_cycle();

        // Withhold credits, at most ARB_CREDITS issues
        drain_credits();
        run_cycle(1'b1, make_uword(YDST_ADRREG, 4'h0), 32'h1234_5678, 1'b0);
        issued = 0;
        repeat (12) run_cycle(1'b1, make_uword(4'h0, 4'h6), $random(seed), 1'b0);
        if (issued != ARB_CREDITS) stop_run("request count with credits withheld is wrong");
        run_cycle(1'b1, make_uword(YDST_ARB, 4'h0), 32'h0000_000b, 1'b0);  // Stalled op
        repeat (5) run_cycle(1'b0, '0, '0, 1'b0);
        run_cycle(1'b0, '0, '0, 1'b1);      // One credit back
        wait_request();
        repeat (500) random_cycle();

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
verilog/besm_uinstr_pkg.sv
verilog/besm_state_pkg.sv
verilog/besm_mode_reg.sv
verilog/besm_cond_mux.sv
verilog/besm_arb_req.sv
verilog/besm_ctl_top.sv
verif/tb_besm_ctl.sv

/* Bender.yml */
package:
  name: besm_ctl

sources:
  # Packages ahead of the modules that import them
  - verilog/besm_uinstr_pkg.sv
  - verilog/besm_state_pkg.sv
  - verilog/besm_mode_reg.sv
  - verilog/besm_cond_mux.sv
  - verilog/besm_arb_req.sv
  - verilog/besm_ctl_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/tb_besm_ctl.sv
